//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks for the pass message
# The exit status is 0 only when the simulation passed

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module tb_pkt_replay -o tb_pkt_replay &&
./obj_dir/tb_pkt_replay | tee /dev/stderr | grep "TESTS PASSED" > /dev/null &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

//--- tb.f
verilog/replay_pkg.sv
verilog/ctrl_edge_sync.sv
verilog/capture_writer.sv
verilog/beat_ram.sv
verilog/replay_reader.sv
verilog/replay_fifo.sv
verilog/pkt_replay_top.sv
verification/pkt_replay_checker.sv
verification/tb_pkt_replay.sv

//--- verification/pkt_replay_checker.sv
// Concurrent checks on the top-level stream ports, bound into pkt_replay_top
// The sw_rst check relies on the 3-flop control synchroniser timing
`timescale 1ns/10ps
`default_nettype none

module pkt_replay_checker (
   input logic              clk,
   input logic              rst_clk,
   input replay_pkg::beat_t m_beat_o,
   input logic              m_valid_o,
   input logic              m_ready_i,
   input logic              s_ready_o,
   input logic              sw_rst_i
);

   int valid_fails  = 0;
   int stable_fails = 0;
   int ready_fails  = 0;

   valid_low_after_reset: assert property (
      @(posedge clk) rst_clk |=> !m_valid_o
   ) else begin
      valid_fails++;
      $error("m_valid_o high in the cycle after reset");
   end

   // A stalled beat holds until taken; only a flush may withdraw it
   beat_stable_while_stalled: assert property (
      @(posedge clk) disable iff (rst_clk)
      (m_valid_o && !m_ready_i) |=> (!m_valid_o || $stable(m_beat_o))
   ) else begin
      stable_fails++;
      $error("m_beat_o changed while stalled");
   end

   no_capture_during_sw_rst: assert property (
      @(posedge clk) disable iff (rst_clk)
      (sw_rst_i && $past(sw_rst_i, 1) && $past(sw_rst_i, 2) && $past(sw_rst_i, 3))
      |-> !s_ready_o
   ) else begin
      ready_fails++;
      $error("s_ready_o high after sw_rst_i held for 4 cycles");
   end

endmodule

bind pkt_replay_top pkt_replay_checker pkt_replay_checker_inst (
   .clk       (clk),
   .rst_clk   (rst_clk),
   .m_beat_o  (m_beat_o),
   .m_valid_o (m_valid_o),
   .m_ready_i (m_ready_i),
   .s_ready_o (s_ready_o),
   .sw_rst_i  (sw_rst_i)
);

`default_nettype wire

//--- verification/tb_pkt_replay.sv
// Testbench for the capture and replay engine, driven from a table of scenarios
// Beat contents and back-pressure come from $random with fixed seeds
// Expected output is the stored packet repeated max(count, 1) times
`timescale 1ns/10ps
`default_nettype none

module tb_pkt_replay;

   localparam int CLK_PERIOD    = 40;
   localparam int DRIVE_DLY     = 2;
   localparam int RST_CYCLES    = 5;
   localparam int NUM_SCEN      = 5;
   localparam int WAIT_LIMIT    = 2000;
   // Control levels must stay put for at least 3 clocks to be seen
   localparam int CTRL_HOLD     = 5;
   localparam int SETTLE_CYCLES = 6;
   localparam int DRAIN_CYCLES  = 30;
   localparam int CMP_W         = 128;
   localparam logic [replay_pkg::CNT_W-1:0] LONG_COUNT = 16'd40;

   typedef struct packed {
      int                           len;
      int                           n_last;
      logic [replay_pkg::CNT_W-1:0] count;
      logic                         bp_en;
      logic                         sw_rst;
   } scenario_t;

   logic                         clk;
   logic                         rst_clk;
   replay_pkg::beat_t            s_beat_i;
   logic                         s_valid_i;
   logic                         s_ready_o;
   replay_pkg::beat_t            m_beat_o;
   logic                         m_valid_o;
   logic                         m_ready_i;
   logic                         start_replay_i;
   logic                         wr_done_i;
   logic                         sw_rst_i;
   logic [replay_pkg::CNT_W-1:0] replay_count_i;

   scenario_t         scenarios [0:NUM_SCEN-1];
   replay_pkg::beat_t stored[$];
   replay_pkg::beat_t expected[$];
   replay_pkg::beat_t received[$];
   integer            seed = 32'hb79b;
   // Own stream so back-pressure does not shift the beat contents
   integer            ready_seed = 32'hb79b ^ 32'h0000_5a5a;
   logic              bp_en;
   int                n_checks;
   int                n_errors;

   pkt_replay_top pkt_replay_top_inst (
      .clk            (clk),
      .rst_clk        (rst_clk),
      .s_beat_i       (s_beat_i),
      .s_valid_i      (s_valid_i),
      .s_ready_o      (s_ready_o),
      .m_beat_o       (m_beat_o),
      .m_valid_o      (m_valid_o),
      .m_ready_i      (m_ready_i),
      .start_replay_i (start_replay_i),
      .wr_done_i      (wr_done_i),
      .sw_rst_i       (sw_rst_i),
      .replay_count_i (replay_count_i)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   initial begin
      m_ready_i = 1'b1;
      forever begin
         @(posedge clk);
         #DRIVE_DLY;
         if (bp_en) begin
            m_ready_i = (($random(ready_seed) & 3) != 0);
         end else begin
            m_ready_i = 1'b1;
         end
      end
   end

   // Valid and ready both high before the edge means the beat transfers on it
   always @(negedge clk) begin
      if (!rst_clk && m_valid_o && m_ready_i) begin
         received.push_back(m_beat_o);
      end
   end

   task automatic check_value(input string name, input logic [CMP_W-1:0] got,
                              input logic [CMP_W-1:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic end_run();
      int assert_fails;
      assert_fails = pkt_replay_top_inst.pkt_replay_checker_inst.valid_fails
                   + pkt_replay_top_inst.pkt_replay_checker_inst.stable_fails
                   + pkt_replay_top_inst.pkt_replay_checker_inst.ready_fails;
      n_errors = n_errors + assert_fails;
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               n_checks, n_errors, assert_fails);
      if (n_errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   endtask

   task automatic report_timeout(input string what);
      $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
      n_errors++;
      end_run();
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_DLY;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) begin
         next_cycle();
      end
   endtask

   task automatic load_scenarios();
      // Length, last flags, count, back-pressure, sw_rst during replay
      scenarios[0] = '{6, 2, 16'd3, 1'b0, 1'b0};
      scenarios[1] = '{5, 1, 16'd0, 1'b0, 1'b0};
      scenarios[2] = '{12, 3, 16'd4, 1'b1, 1'b0};
      scenarios[3] = '{4, 2, 16'd2, 1'b1, 1'b0};
      scenarios[4] = '{7, 1, 16'd2, 1'b1, 1'b1};
   endtask

   task automatic make_beats(input int len, input int n_last);
      replay_pkg::beat_t b;
      logic [31:0]       rnd;
      int                pkt_len;
      int                i;
      pkt_len = len / n_last;
      stored.delete();
      for (i = 0; i < len; i++) begin
         b.data = {$random(seed), $random(seed)};
         rnd    = $random(seed);
         b.keep = rnd[replay_pkg::KEEP_W-1:0];
         rnd    = $random(seed);
         b.user = rnd[replay_pkg::USER_W-1:0];
         b.last = ((i + 1) % pkt_len == 0) || (i == len - 1);
         stored.push_back(b);
      end
   endtask

   task automatic send_beat(input replay_pkg::beat_t b);
      int   waited;
      logic taken;
      s_beat_i  = b;
      s_valid_i = 1'b1;
      taken     = 1'b0;
      waited    = 0;
      while (!taken) begin
         @(negedge clk);
         taken = s_ready_o;
         next_cycle();
         waited++;
         if (waited > WAIT_LIMIT) begin
            report_timeout("s_ready_o to accept an input beat");
         end
      end
      s_valid_i = 1'b0;
   endtask

   task automatic capture_stored();
      foreach (stored[i]) begin
         send_beat(stored[i]);
      end
   endtask

   task automatic pulse_wr_done();
      wr_done_i = 1'b1;
      wait_cycles(CTRL_HOLD);
      wr_done_i = 1'b0;
      wait_cycles(CTRL_HOLD);
   endtask

   task automatic start_replay(input logic [replay_pkg::CNT_W-1:0] count);
      replay_count_i = count;
      start_replay_i = 1'b1;
      wait_cycles(CTRL_HOLD);
      start_replay_i = 1'b0;
      wait_cycles(CTRL_HOLD);
   endtask

   task automatic wait_for_beats(input int n);
      int waited;
      waited = 0;
      while (received.size() < n) begin
         next_cycle();
         waited++;
         if (waited > WAIT_LIMIT) begin
            report_timeout($sformatf("%0d output beats, %0d arrived", n, received.size()));
         end
      end
   endtask

   task automatic compare_output();
      int n;
      int i;
      check_value("output beat count", CMP_W'(received.size()), CMP_W'(expected.size()));
      n = (received.size() < expected.size()) ? received.size() : expected.size();
      for (i = 0; i < n; i++) begin
         check_value($sformatf("m_beat_o[%0d]", i), CMP_W'(received[i]), CMP_W'(expected[i]));
      end
   endtask

   // Long replay cut short by sw_rst, output must go quiet once clear settles
   task automatic interrupt_replay();
      received.delete();
      start_replay(LONG_COUNT);
      wait_for_beats(4);
      sw_rst_i = 1'b1;
      wait_cycles(SETTLE_CYCLES);
      check_value("s_ready_o", CMP_W'(s_ready_o), CMP_W'(1'b0));
      received.delete();
      wait_cycles(DRAIN_CYCLES);
      check_value("beats after clear", CMP_W'(received.size()), CMP_W'(0));
      sw_rst_i = 1'b0;
      wait_cycles(SETTLE_CYCLES);
   endtask

   task automatic run_scenario(input scenario_t sc);
      int passes;
      int p;
      bp_en = sc.bp_en;
      make_beats(sc.len, sc.n_last);
      capture_stored();
      pulse_wr_done();
      if (sc.sw_rst) begin
         interrupt_replay();
         make_beats(sc.len, sc.n_last);
         capture_stored();
         pulse_wr_done();
      end
      // A count of zero still plays the packet once
      passes = (sc.count == '0) ? 1 : int'(sc.count);
      expected.delete();
      for (p = 0; p < passes; p++) begin
         foreach (stored[i]) begin
            expected.push_back(stored[i]);
         end
      end
      received.delete();
      start_replay(sc.count);
      wait_for_beats(expected.size());
      wait_cycles(DRAIN_CYCLES);
      compare_output();
   endtask

   initial begin
      int k;
      n_checks       = 0;
      n_errors       = 0;
      rst_clk        = 1'b1;
      s_beat_i       = '0;
      s_valid_i      = 1'b0;
      start_replay_i = 1'b0;
      wr_done_i      = 1'b0;
      sw_rst_i       = 1'b0;
      replay_count_i = '0;
      bp_en          = 1'b0;
      load_scenarios();
      repeat (RST_CYCLES) begin
         @(posedge clk);
      end
      #DRIVE_DLY;
      rst_clk = 1'b0;
      next_cycle();
      check_value("m_valid_o", CMP_W'(m_valid_o), CMP_W'(1'b0));
      check_value("s_ready_o", CMP_W'(s_ready_o), CMP_W'(1'b1));
      for (k = 0; k < NUM_SCEN; k++) begin
         run_scenario(scenarios[k]);
      end
      end_run();
   end

endmodule

`default_nettype wire

//--- verilog/beat_ram.sv
// Simple dual-port beat memory, one write port and one read port
// Read data is registered, so it arrives one cycle after re_i
// A read of the address being written returns the old contents
`timescale 1ns/10ps
`default_nettype none

module beat_ram (
   input  logic                           clk,
   input  logic                           rst_clk,
   input  logic                           we_i,
   input  logic [replay_pkg::ADDR_W-1:0]  waddr_i,
   input  replay_pkg::beat_t              wbeat_i,
   input  logic                           re_i,
   input  logic [replay_pkg::ADDR_W-1:0]  raddr_i,
   output replay_pkg::beat_t              rbeat_o,
   output logic                           rvalid_o
);

   replay_pkg::beat_t mem [0:(1 << replay_pkg::ADDR_W)-1];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= wbeat_i;
      end
   end

   always_ff @(posedge clk) begin
      if (re_i) begin
         rbeat_o <= mem[raddr_i];
      end
   end

   always_ff @(posedge clk) begin
      if (rst_clk) begin
         rvalid_o <= 1'b0;
      end else begin
         rvalid_o <= re_i;
      end
   end

endmodule

`default_nettype wire

//--- verilog/capture_writer.sv
// Writes each accepted input beat straight into the beat memory
// Capture stops once all 1024 beats are used, until wr_done or clear
`timescale 1ns/10ps
`default_nettype none

module capture_writer (
   input  logic                           clk,
   input  logic                           rst_clk,
   input  replay_pkg::beat_t              s_beat_i,
   input  logic                           s_valid_i,
   output logic                           s_ready_o,
   input  logic                           wr_done_i,
   input  logic                           clear_i,
   output logic                           mem_we_o,
   output logic [replay_pkg::ADDR_W-1:0]  mem_waddr_o,
   output replay_pkg::beat_t              mem_wbeat_o,
   output logic [replay_pkg::ADDR_W-1:0]  end_addr_o
);

   logic [replay_pkg::ADDR_W-1:0] wr_addr;
   logic                          full;
   logic                          accept;

   assign s_ready_o   = ~clear_i & ~full;
   assign accept      = s_valid_i & s_ready_o;

   // Write port follows the accepted beat in the same cycle
   assign mem_we_o    = accept;
   assign mem_waddr_o = wr_addr;
   assign mem_wbeat_o = s_beat_i;

   always_ff @(posedge clk) begin
      if (rst_clk || clear_i) begin
         wr_addr    <= '0;
         full       <= 1'b0;
         end_addr_o <= '0;
      end else begin
         if (accept) begin
            end_addr_o <= wr_addr;
            wr_addr    <= wr_addr + 1'b1;
            if (&wr_addr) begin
               full <= 1'b1;
            end
         end
         // Next capture starts over at address 0
         if (wr_done_i) begin
            wr_addr <= '0;
            full    <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/ctrl_edge_sync.sv
// Control inputs are asynchronous levels; only their synchronised edges act
// A level must stay stable for at least 3 clocks to be seen
`timescale 1ns/10ps
`default_nettype none

module ctrl_edge_sync (
   input  logic                           clk,
   input  logic                           rst_clk,
   input  logic                           start_replay_i,
   input  logic                           wr_done_i,
   input  logic                           sw_rst_i,
   input  logic [replay_pkg::CNT_W-1:0]   replay_count_i,
   output logic                           start_o,
   output logic                           wr_done_o,
   output logic                           clear_o,
   output logic [replay_pkg::CNT_W-1:0]   replay_count_o
);

   logic [2:0] start_sr;
   logic [2:0] wr_done_sr;
   logic [2:0] sw_rst_sr;
   logic       start_rise;
   logic       sw_rst_rise;
   logic       sw_rst_fall;

   // Two sync stages, third stage keeps the previous value for edge detect
   always_ff @(posedge clk) begin
      if (rst_clk) begin
         start_sr   <= '0;
         wr_done_sr <= '0;
         sw_rst_sr  <= '0;
      end else begin
         start_sr   <= {start_sr[1:0], start_replay_i};
         wr_done_sr <= {wr_done_sr[1:0], wr_done_i};
         sw_rst_sr  <= {sw_rst_sr[1:0], sw_rst_i};
      end
   end

   assign start_rise  = start_sr[1] & ~start_sr[2];
   assign wr_done_o   = wr_done_sr[1] & ~wr_done_sr[2];
   assign sw_rst_rise = sw_rst_sr[1] & ~sw_rst_sr[2];
   assign sw_rst_fall = ~sw_rst_sr[1] & sw_rst_sr[2];

   // No replay may start during a software reset
   assign start_o = start_rise & ~clear_o;

   always_ff @(posedge clk) begin
      if (rst_clk) begin
         clear_o <= 1'b0;
      end else if (sw_rst_rise) begin
         clear_o <= 1'b1;
      end else if (sw_rst_fall) begin
         clear_o <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_clk || clear_o) begin
         replay_count_o <= '0;
      end else if (start_o) begin
         replay_count_o <= replay_count_i;
      end
   end

endmodule

`default_nettype wire

//--- verilog/pkt_replay_top.sv
// Packet capture and replay engine, everything on one clock
// Capture and replay use separate memory ports and may overlap in time
// Control inputs are levels; see ctrl_edge_sync for their timing
`timescale 1ns/10ps
`default_nettype none

module pkt_replay_top (
   input  logic                           clk,
   input  logic                           rst_clk,
   input  replay_pkg::beat_t              s_beat_i,
   input  logic                           s_valid_i,
   output logic                           s_ready_o,
   output replay_pkg::beat_t              m_beat_o,
   output logic                           m_valid_o,
   input  logic                           m_ready_i,
   input  logic                           start_replay_i,
   input  logic                           wr_done_i,
   input  logic                           sw_rst_i,
   input  logic [replay_pkg::CNT_W-1:0]   replay_count_i
);

   logic                          start;
   logic                          wr_done;
   logic                          clear;
   logic [replay_pkg::CNT_W-1:0]  replay_count;
   logic                          mem_we;
   logic [replay_pkg::ADDR_W-1:0] mem_waddr;
   replay_pkg::beat_t             mem_wbeat;
   logic [replay_pkg::ADDR_W-1:0] end_addr;
   logic                          mem_re;
   logic [replay_pkg::ADDR_W-1:0] mem_raddr;
   replay_pkg::beat_t             mem_rbeat;
   logic                          mem_rvalid;
   logic                          fifo_empty;
   logic                          fifo_nearly_full;
   logic                          fifo_rd;

   assign m_valid_o = ~fifo_empty;
   assign fifo_rd   = m_valid_o & m_ready_i;

   ctrl_edge_sync ctrl_edge_sync_inst (
      .clk            (clk),
      .rst_clk        (rst_clk),
      .start_replay_i (start_replay_i),
      .wr_done_i      (wr_done_i),
      .sw_rst_i       (sw_rst_i),
      .replay_count_i (replay_count_i),
      .start_o        (start),
      .wr_done_o      (wr_done),
      .clear_o        (clear),
      .replay_count_o (replay_count)
   );

   capture_writer capture_writer_inst (
      .clk         (clk),
      .rst_clk     (rst_clk),
      .s_beat_i    (s_beat_i),
      .s_valid_i   (s_valid_i),
      .s_ready_o   (s_ready_o),
      .wr_done_i   (wr_done),
      .clear_i     (clear),
      .mem_we_o    (mem_we),
      .mem_waddr_o (mem_waddr),
      .mem_wbeat_o (mem_wbeat),
      .end_addr_o  (end_addr)
   );

   beat_ram beat_ram_inst (
      .clk      (clk),
      .rst_clk  (rst_clk),
      .we_i     (mem_we),
      .waddr_i  (mem_waddr),
      .wbeat_i  (mem_wbeat),
      .re_i     (mem_re),
      .raddr_i  (mem_raddr),
      .rbeat_o  (mem_rbeat),
      .rvalid_o (mem_rvalid)
   );

   replay_reader replay_reader_inst (
      .clk                (clk),
      .rst_clk            (rst_clk),
      .start_i            (start),
      .clear_i            (clear),
      .replay_count_i     (replay_count),
      .end_addr_i         (end_addr),
      .fifo_nearly_full_i (fifo_nearly_full),
      .re_o               (mem_re),
      .raddr_o            (mem_raddr)
   );

   // Reads already in flight at a clear land while flush is still high
   replay_fifo replay_fifo_inst (
      .clk           (clk),
      .rst_clk       (rst_clk),
      .wr_en_i       (mem_rvalid),
      .din_i         (mem_rbeat),
      .rd_en_i       (fifo_rd),
      .flush_i       (clear),
      .dout_o        (m_beat_o),
      .empty_o       (fifo_empty),
      .nearly_full_o (fifo_nearly_full)
   );

endmodule

`default_nettype wire

//--- verilog/replay_fifo.sv
// First-word-fall-through FIFO; dout_o is valid whenever empty_o is low
// Writes while full are not guarded, the nearly-full margin must prevent them
`timescale 1ns/10ps
`default_nettype none

module replay_fifo (
   input  logic               clk,
   input  logic               rst_clk,
   input  logic               wr_en_i,
   input  replay_pkg::beat_t  din_i,
   input  logic               rd_en_i,
   input  logic               flush_i,
   output replay_pkg::beat_t  dout_o,
   output logic               empty_o,
   output logic               nearly_full_o
);

   replay_pkg::beat_t                    mem [0:(1 << replay_pkg::FIFO_DEPTH_BITS)-1];
   logic [replay_pkg::FIFO_DEPTH_BITS-1:0] wr_ptr;
   logic [replay_pkg::FIFO_DEPTH_BITS-1:0] rd_ptr;
   logic [replay_pkg::FIFO_DEPTH_BITS:0]   count;
   logic                                   do_rd;

   assign empty_o = (count == '0);
   assign do_rd   = rd_en_i & ~empty_o;
   assign dout_o  = mem[rd_ptr];

   // High once fewer than FIFO_MARGIN slots are free
   assign nearly_full_o = count > (replay_pkg::FIFO_DEPTH_BITS + 1)'(
      (1 << replay_pkg::FIFO_DEPTH_BITS) - replay_pkg::FIFO_MARGIN);

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_ptr] <= din_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_clk || flush_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en_i, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/replay_pkg.sv
// Sizes and shared types for the capture and replay engine
// All sizes are fixed here; the design has no module parameters
`default_nettype none

package replay_pkg;

   localparam int DATA_W          = 64;
   localparam int KEEP_W          = DATA_W / 8;
   localparam int USER_W          = 16;

   // 1024 beats of storage
   localparam int ADDR_W          = 10;
   localparam int CNT_W           = 16;

   // Output FIFO of 16 entries
   localparam int FIFO_DEPTH_BITS = 4;
   // Covers the reads still in flight when nearly-full rises
   localparam int FIFO_MARGIN     = 3;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [KEEP_W-1:0] keep;
      logic [USER_W-1:0] user;
      logic              last;
   } beat_t;

   typedef enum logic [1:0] {
      RD_IDLE     = 2'd0,
      RD_READING  = 2'd1,
      RD_PASS_END = 2'd2
   } rd_state_t;

endpackage

`default_nettype wire

//--- verilog/replay_reader.sv
// Reads addresses 0 to end_addr_i once per pass, at most one read a cycle
// Runs max(count, 1) passes; start is ignored until it is back in idle
`timescale 1ns/10ps
`default_nettype none

module replay_reader (
   input  logic                           clk,
   input  logic                           rst_clk,
   input  logic                           start_i,
   input  logic                           clear_i,
   input  logic [replay_pkg::CNT_W-1:0]   replay_count_i,
   input  logic [replay_pkg::ADDR_W-1:0]  end_addr_i,
   input  logic                           fifo_nearly_full_i,
   output logic                           re_o,
   output logic [replay_pkg::ADDR_W-1:0]  raddr_o
);

   replay_pkg::rd_state_t          state;
   logic [replay_pkg::ADDR_W-1:0]  rd_addr;
   logic [replay_pkg::CNT_W-1:0]   pass_cnt;
   logic                           at_end;

   // Hold off reads while the output FIFO is close to full
   assign re_o    = (state == replay_pkg::RD_READING) & ~fifo_nearly_full_i;
   assign raddr_o = rd_addr;
   assign at_end  = (rd_addr == end_addr_i);

   always_ff @(posedge clk) begin
      if (rst_clk || clear_i) begin
         state    <= replay_pkg::RD_IDLE;
         rd_addr  <= '0;
         pass_cnt <= '0;
      end else begin
         case (state)
            replay_pkg::RD_IDLE: begin
               if (start_i) begin
                  state    <= replay_pkg::RD_READING;
                  rd_addr  <= '0;
                  pass_cnt <= '0;
               end
            end
            replay_pkg::RD_READING: begin
               if (re_o) begin
                  if (at_end) begin
                     pass_cnt <= pass_cnt + 1'b1;
                     state    <= replay_pkg::RD_PASS_END;
                  end else begin
                     rd_addr <= rd_addr + 1'b1;
                  end
               end
            end
            replay_pkg::RD_PASS_END: begin
               rd_addr <= '0;
               // A count of 0 still ends here after the first pass
               if (pass_cnt < replay_count_i) begin
                  state <= replay_pkg::RD_READING;
               end else begin
                  state <= replay_pkg::RD_IDLE;
               end
            end
            default: begin
               state <= replay_pkg::RD_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire
